/* include/alua_defines.svh */
// ALU A select bit positions
`ifndef ALUA_DEFINES_SVH
`define ALUA_DEFINES_SVH

// Top index of the one-hot ALU A select word.
`define ALUA_IDX 14

// Constant sources.
`define AA_ONE  0
`define AA_M1   1
`define AA_M2   2
// Register pair and index sources.
`define AA_HL   3
`define AA_IX   4
`define AA_IY   5
`define AA_PC   6
// Byte-wide sources, zero-extended in the mux.
`define AA_AA   7
`define AA_BIT  8
`define AA_DAA  9
`define AA_II   10
`define AA_RR   11
// Interrupt vector address.
`define AA_INT  12
`define AA_TMP  13
`define AA_RST  14

`endif

/* verilog/dp_pkg.sv */
// Datapath shared types
package dp_pkg;

  // Bus widths.
  localparam int WORD_W = 16;
  localparam int BYTE_W = 8;
  localparam int ALUB_W = 4;

  // ALU B select bit positions within the one-hot word.
  localparam int B_IMM = 0;
  localparam int B_TMP = 1;
  localparam int B_HL  = 2;
  localparam int B_A   = 3;

  // ALU operation.
  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_AND   = 3'd2,
    OP_OR    = 3'd3,
    OP_XOR   = 3'd4,
    OP_PASSA = 3'd5
  } alu_op_e;

  // Write-back destination; D_NONE writes nothing.
  typedef enum logic [3:0] {
    D_NONE = 4'd0,
    D_A    = 4'd1,
    D_HL   = 4'd2,
    D_IX   = 4'd3,
    D_IY   = 4'd4,
    D_PC   = 4'd5,
    D_TMP  = 4'd6,
    D_I    = 4'd7,
    D_R    = 4'd8
  } dest_e;

  // Displacement in the upper byte, data in the lower byte.
  typedef struct packed {
    logic [BYTE_W-1:0] disp;
    logic [BYTE_W-1:0] data;
  } imm_split_t;

  // Immediate operand, seen as one constant or as two bytes.
  typedef union packed {
    logic [WORD_W-1:0] word;
    imm_split_t        split;
  } imm_word_u;

  typedef struct packed {
    logic zero;
    logic sign;
    logic carry;
  } flags_t;

endpackage

/* verilog/ctl_reg.sv */
// Micro-operation control register
`timescale 1ns/10ps
`include "alua_defines.svh"

module ctl_reg import dp_pkg::*; (
  input  logic                clkc,
  input  logic                rst_n,
  input  logic                uop_valid,
  input  logic [`ALUA_IDX:0]  alua_sel,
  input  logic [ALUB_W-1:0]   alub_sel,
  input  alu_op_e             alu_op,
  input  dest_e               dest,
  input  logic                addr_ld,
  input  imm_word_u           imm,
  input  logic [2:0]          bit_num,
  input  logic [2:0]          rst_vec,
  output logic [`ALUA_IDX:0]  alua_reg,
  output logic [ALUB_W-1:0]   alub_reg,
  output alu_op_e             op_reg,
  output dest_e               dest_reg,
  output logic                ld_reg,
  output imm_word_u           imm_reg,
  output logic [BYTE_W-1:0]   bit_mask,
  output logic [BYTE_W-1:0]   rst_addr,
  output logic                stage_valid
);

  // Selects and strobes; cleared on idle cycles so nothing is written.
  always_ff @(posedge clkc or negedge rst_n) begin
    if (!rst_n) begin
      alua_reg    <= '0;
      alub_reg    <= '0;
      op_reg      <= OP_ADD;
      dest_reg    <= D_NONE;
      ld_reg      <= 1'b0;
      stage_valid <= 1'b0;
    end else if (uop_valid) begin
      alua_reg    <= alua_sel;
      alub_reg    <= alub_sel;
      op_reg      <= alu_op;
      dest_reg    <= dest;
      ld_reg      <= addr_ld;
      stage_valid <= 1'b1;
    end else begin
      alua_reg    <= '0;
      alub_reg    <= '0;
      dest_reg    <= D_NONE;
      ld_reg      <= 1'b0;
      stage_valid <= 1'b0;
    end
  end

  // Operand payload.
  // Bit number becomes a one-hot mask, restart vector becomes vec*8.
  always_ff @(posedge clkc) begin
    if (uop_valid) begin
      imm_reg  <= imm;
      bit_mask <= 8'h01 << bit_num;
      rst_addr <= {2'b00, rst_vec, 3'b000};
    end
  end

endmodule

/* verilog/reg_bank.sv */
// Processor register bank
`timescale 1ns/10ps

module reg_bank import dp_pkg::*; #(
  parameter logic [15:0] RESET_PC = 16'h0000
) (
  input  logic              clkc,
  input  logic              rst_n,
  input  logic              stage_valid,
  input  dest_e             dest_reg,
  input  logic [WORD_W-1:0] result,
  input  flags_t            flags_in,
  input  logic [BYTE_W-1:0] int_vec,
  output logic [BYTE_W-1:0] aa_reg_out,
  output logic [WORD_W-1:0] hl_reg_out,
  output logic [WORD_W-1:0] ix_reg,
  output logic [WORD_W-1:0] iy_reg,
  output logic [WORD_W-1:0] pc_reg,
  output logic [BYTE_W-1:0] ii_reg,
  output logic [BYTE_W-1:0] rr_reg,
  output logic [WORD_W-1:0] tmp_reg,
  output logic [WORD_W-1:0] int_addr,
  output flags_t            flags
);

  // Write-back at the end of the stage cycle.
  always_ff @(posedge clkc or negedge rst_n) begin
    if (!rst_n) begin
      aa_reg_out <= '0;
      hl_reg_out <= '0;
      ix_reg     <= '0;
      iy_reg     <= '0;
      pc_reg     <= RESET_PC;
      ii_reg     <= '0;
      rr_reg     <= '0;
      tmp_reg    <= '0;
      flags      <= '0;
    end else if (stage_valid) begin
      // Flags follow every valid stage.
      flags <= flags_in;
      // Refresh counter, bit 7 is kept as loaded.
      rr_reg <= {rr_reg[7], rr_reg[6:0] + 7'd1};
      case (dest_reg)
        D_A:     aa_reg_out <= result[BYTE_W-1:0];
        D_HL:    hl_reg_out <= result;
        D_IX:    ix_reg     <= result;
        D_IY:    iy_reg     <= result;
        D_PC:    pc_reg     <= result;
        D_TMP:   tmp_reg    <= result;
        D_I:     ii_reg     <= result[BYTE_W-1:0];
        // An explicit load of R overrides the increment.
        D_R:     rr_reg     <= result[BYTE_W-1:0];
        default: ;
      endcase
    end
  end

  // Mode 2 style vector: I on top, device byte below.
  assign int_addr = {ii_reg, int_vec};

endmodule

/* verilog/aluamux.sv */
// ALU A operand multiplexer
`timescale 1ns/10ps
`include "alua_defines.svh"

module aluamux (
  output logic [15:0]        adda_in,
  output logic [15:0]        alua_in,
  input  logic [`ALUA_IDX:0] alua_reg,
  input  logic [7:0]         aa_reg_out,
  input  logic [7:0]         bit_mask,
  input  logic [7:0]         daa_out,
  input  logic [15:0]        hl_reg_out,
  input  logic [7:0]         ii_reg,
  input  logic [15:0]        int_addr,
  input  logic [15:0]        ix_reg,
  input  logic [15:0]        iy_reg,
  input  logic [15:0]        pc_reg,
  input  logic [7:0]         rr_reg,
  input  logic [7:0]         rst_addr,
  input  logic [15:0]        tmp_reg
);

  // One-hot OR mux.
  // An all-zero select gives zero, which the sequencer uses for loads.
  always_comb begin
    alua_in = 16'h0000;
    // Constants.
    alua_in = alua_in | ({16{alua_reg[`AA_ONE]}} & 16'h0001);
    alua_in = alua_in | ({16{alua_reg[`AA_M1]}}  & 16'hffff);
    alua_in = alua_in | ({16{alua_reg[`AA_M2]}}  & 16'hfffe);
    // Word registers.
    alua_in = alua_in | ({16{alua_reg[`AA_HL]}}  & hl_reg_out);
    alua_in = alua_in | ({16{alua_reg[`AA_IX]}}  & ix_reg);
    alua_in = alua_in | ({16{alua_reg[`AA_IY]}}  & iy_reg);
    alua_in = alua_in | ({16{alua_reg[`AA_PC]}}  & pc_reg);
    alua_in = alua_in | ({16{alua_reg[`AA_TMP]}} & tmp_reg);
    alua_in = alua_in | ({16{alua_reg[`AA_INT]}} & int_addr);
    // Byte sources, zero-extended.
    alua_in = alua_in | ({16{alua_reg[`AA_AA]}}  & {8'h00, aa_reg_out});
    alua_in = alua_in | ({16{alua_reg[`AA_BIT]}} & {8'h00, bit_mask});
    alua_in = alua_in | ({16{alua_reg[`AA_DAA]}} & {8'h00, daa_out});
    alua_in = alua_in | ({16{alua_reg[`AA_II]}}  & {8'h00, ii_reg});
    alua_in = alua_in | ({16{alua_reg[`AA_RR]}}  & {8'h00, rr_reg});
    alua_in = alua_in | ({16{alua_reg[`AA_RST]}} & {8'h00, rst_addr});
  end

  // Address adder only needs the index, vector and constant sources.
  always_comb begin
    adda_in = 16'h0000;
    adda_in = adda_in | ({16{alua_reg[`AA_ONE]}} & 16'h0001);
    adda_in = adda_in | ({16{alua_reg[`AA_M1]}}  & 16'hffff);
    adda_in = adda_in | ({16{alua_reg[`AA_M2]}}  & 16'hfffe);
    adda_in = adda_in | ({16{alua_reg[`AA_IX]}}  & ix_reg);
    adda_in = adda_in | ({16{alua_reg[`AA_IY]}}  & iy_reg);
    adda_in = adda_in | ({16{alua_reg[`AA_INT]}} & int_addr);
    adda_in = adda_in | ({16{alua_reg[`AA_RST]}} & {8'h00, rst_addr});
  end

endmodule

/* verilog/alubmux.sv */
// ALU B operand multiplexer
`timescale 1ns/10ps

module alubmux import dp_pkg::*; (
  input  logic [ALUB_W-1:0] alub_reg,
  input  imm_word_u         imm_reg,
  input  logic [WORD_W-1:0] tmp_reg,
  input  logic [WORD_W-1:0] hl_reg_out,
  input  logic [BYTE_W-1:0] aa_reg_out,
  output logic [WORD_W-1:0] alub_in
);

  // Same OR structure as the A side, zero when nothing is selected.
  always_comb begin
    alub_in = '0;
    // Immediate taken as one 16-bit constant.
    alub_in = alub_in | ({WORD_W{alub_reg[B_IMM]}} & imm_reg.word);
    alub_in = alub_in | ({WORD_W{alub_reg[B_TMP]}} & tmp_reg);
    alub_in = alub_in | ({WORD_W{alub_reg[B_HL]}}  & hl_reg_out);
    // Accumulator zero-extended.
    alub_in = alub_in | ({WORD_W{alub_reg[B_A]}}   & {8'h00, aa_reg_out});
  end

endmodule

/* verilog/alu_core.sv */
// 16-bit ALU
`timescale 1ns/10ps

module alu_core import dp_pkg::*; (
  input  logic [WORD_W-1:0] alua_in,
  input  logic [WORD_W-1:0] alub_in,
  input  alu_op_e           op_reg,
  input  logic              carry_in,
  input  logic [BYTE_W-1:0] aa_reg_out,
  output logic [WORD_W-1:0] result,
  output flags_t            flags_out,
  output logic [BYTE_W-1:0] daa_out
);

  // Result with the carry or borrow out on top.
  logic [WORD_W:0]   wide;
  logic [BYTE_W-1:0] daa_lo;
  logic [BYTE_W-1:0] daa_hi;

  always_comb begin
    case (op_reg)
      OP_ADD:   wide = {1'b0, alua_in} + {1'b0, alub_in};
      // Bit 16 becomes the borrow.
      OP_SUB:   wide = {1'b0, alua_in} - {1'b0, alub_in};
      OP_AND:   wide = {1'b0, alua_in & alub_in};
      OP_OR:    wide = {1'b0, alua_in | alub_in};
      OP_XOR:   wide = {1'b0, alua_in ^ alub_in};
      OP_PASSA: wide = {1'b0, alua_in};
      default:  wide = '0;
    endcase
  end

  assign result = wide[WORD_W-1:0];

  // Logic ops and pass leave bit 16 clear, so carry is zero there.
  assign flags_out.zero  = (result == '0);
  assign flags_out.sign  = result[WORD_W-1];
  assign flags_out.carry = wide[WORD_W];

  // Decimal adjust constant from the stored A and carry.
  // Kept apart from the result so the A mux sees no loop.
  assign daa_lo  = (aa_reg_out[3:0] > 4'd9) ? 8'h06 : 8'h00;
  assign daa_hi  = ((aa_reg_out[7:4] > 4'd9) || carry_in) ? 8'h60 : 8'h00;
  assign daa_out = daa_lo | daa_hi;

endmodule

/* verilog/addr_alu.sv */
// Effective address adder
`timescale 1ns/10ps

module addr_alu import dp_pkg::*; (
  input  logic              clkc,
  input  logic              rst_n,
  input  logic              stage_valid,
  input  logic              ld_reg,
  input  logic [WORD_W-1:0] adda_in,
  input  imm_word_u         imm_reg,
  output logic [WORD_W-1:0] addr_out
);

  // Displacement is the upper byte of the immediate, signed.
  logic [WORD_W-1:0] disp_ext;

  assign disp_ext = {{BYTE_W{imm_reg.split.disp[BYTE_W-1]}}, imm_reg.split.disp};

  // Address register holds until the next load.
  always_ff @(posedge clkc or negedge rst_n) begin
    if (!rst_n) begin
      addr_out <= '0;
    end else if (stage_valid && ld_reg) begin
      addr_out <= adda_in + disp_ext;
    end
  end

endmodule

/* verilog/dp_top.sv */
// Datapath slice top level
`timescale 1ns/10ps
`include "alua_defines.svh"

module dp_top import dp_pkg::*; #(
  parameter logic [15:0] RESET_PC = 16'h0000
) (
  input  logic               clkc,
  input  logic               rst_n,
  input  logic               uop_valid,
  input  logic [`ALUA_IDX:0] alua_sel,
  input  logic [ALUB_W-1:0]  alub_sel,
  input  alu_op_e            alu_op,
  input  dest_e              dest,
  input  logic               addr_ld,
  input  imm_word_u          imm,
  input  logic [2:0]         bit_num,
  input  logic [2:0]         rst_vec,
  input  logic [BYTE_W-1:0]  int_vec,
  output logic [WORD_W-1:0]  alu_out,
  output flags_t             flags,
  output logic [WORD_W-1:0]  addr_out,
  output logic [BYTE_W-1:0]  a_out,
  output logic [WORD_W-1:0]  hl_out,
  output logic [WORD_W-1:0]  pc_out
);

  // Control stage outputs.
  logic [`ALUA_IDX:0] alua_reg;
  logic [ALUB_W-1:0]  alub_reg;
  alu_op_e            op_reg;
  dest_e              dest_reg;
  logic               ld_reg;
  imm_word_u          imm_reg;
  logic [BYTE_W-1:0]  bit_mask;
  logic [BYTE_W-1:0]  rst_addr;
  logic               stage_valid;
  // Register bank outputs not seen at the top.
  logic [WORD_W-1:0]  ix_reg;
  logic [WORD_W-1:0]  iy_reg;
  logic [BYTE_W-1:0]  ii_reg;
  logic [BYTE_W-1:0]  rr_reg;
  logic [WORD_W-1:0]  tmp_reg;
  logic [WORD_W-1:0]  int_addr;
  // Operand buses and ALU flags before the flag register.
  logic [WORD_W-1:0]  alua_in;
  logic [WORD_W-1:0]  adda_in;
  logic [WORD_W-1:0]  alub_in;
  flags_t             alu_flags;
  logic [BYTE_W-1:0]  daa_out;

  ctl_reg u_ctl_reg (
    .clkc        (clkc),
    .rst_n       (rst_n),
    .uop_valid   (uop_valid),
    .alua_sel    (alua_sel),
    .alub_sel    (alub_sel),
    .alu_op      (alu_op),
    .dest        (dest),
    .addr_ld     (addr_ld),
    .imm         (imm),
    .bit_num     (bit_num),
    .rst_vec     (rst_vec),
    .alua_reg    (alua_reg),
    .alub_reg    (alub_reg),
    .op_reg      (op_reg),
    .dest_reg    (dest_reg),
    .ld_reg      (ld_reg),
    .imm_reg     (imm_reg),
    .bit_mask    (bit_mask),
    .rst_addr    (rst_addr),
    .stage_valid (stage_valid)
  );

  // Top flags output is the flag register, updated at stage end.
  reg_bank #(
    .RESET_PC (RESET_PC)
  ) u_reg_bank (
    .clkc        (clkc),
    .rst_n       (rst_n),
    .stage_valid (stage_valid),
    .dest_reg    (dest_reg),
    .result      (alu_out),
    .flags_in    (alu_flags),
    .int_vec     (int_vec),
    .aa_reg_out  (a_out),
    .hl_reg_out  (hl_out),
    .ix_reg      (ix_reg),
    .iy_reg      (iy_reg),
    .pc_reg      (pc_out),
    .ii_reg      (ii_reg),
    .rr_reg      (rr_reg),
    .tmp_reg     (tmp_reg),
    .int_addr    (int_addr),
    .flags       (flags)
  );

  aluamux u_aluamux (
    .adda_in    (adda_in),
    .alua_in    (alua_in),
    .alua_reg   (alua_reg),
    .aa_reg_out (a_out),
    .bit_mask   (bit_mask),
    .daa_out    (daa_out),
    .hl_reg_out (hl_out),
    .ii_reg     (ii_reg),
    .int_addr   (int_addr),
    .ix_reg     (ix_reg),
    .iy_reg     (iy_reg),
    .pc_reg     (pc_out),
    .rr_reg     (rr_reg),
    .rst_addr   (rst_addr),
    .tmp_reg    (tmp_reg)
  );

  alubmux u_alubmux (
    .alub_reg   (alub_reg),
    .imm_reg    (imm_reg),
    .tmp_reg    (tmp_reg),
    .hl_reg_out (hl_out),
    .aa_reg_out (a_out),
    .alub_in    (alub_in)
  );

  // Carry in for DAA comes from the stored flags.
  alu_core u_alu_core (
    .alua_in    (alua_in),
    .alub_in    (alub_in),
    .op_reg     (op_reg),
    .carry_in   (flags.carry),
    .aa_reg_out (a_out),
    .result     (alu_out),
    .flags_out  (alu_flags),
    .daa_out    (daa_out)
  );

  addr_alu u_addr_alu (
    .clkc        (clkc),
    .rst_n       (rst_n),
    .stage_valid (stage_valid),
    .ld_reg      (ld_reg),
    .adda_in     (adda_in),
    .imm_reg     (imm_reg),
    .addr_out    (addr_out)
  );

endmodule

/* test/tb_dp.sv */
// Datapath slice testbench
`timescale 1ns/10ps
`include "alua_defines.svh"

module tb_dp import dp_pkg::*; ();

  localparam logic [15:0] RESET_PC = 16'h0100;
  localparam int RST_CYCLES = 5;
  localparam int N_RAND     = 330;
  localparam int N_PAIRS    = 60;
  // Loads and readbacks, random phase, up to three cycles per pair, then margin.
  localparam int MAX_CYCLES = RST_CYCLES + 16 + N_RAND + 3 * N_PAIRS + 64;

  // One micro-operation as the sequencer sends it.
  typedef struct packed {
    logic               valid;
    logic [`ALUA_IDX:0] asel;
    logic [ALUB_W-1:0]  bsel;
    alu_op_e            op;
    dest_e              dst;
    logic               ld;
    logic [15:0]        imm;
    logic [2:0]         bn;
    logic [2:0]         rv;
  } uop_t;

  logic               clkc;
  logic               rst_n;
  logic               uop_valid;
  logic [`ALUA_IDX:0] alua_sel;
  logic [ALUB_W-1:0]  alub_sel;
  alu_op_e            alu_op;
  dest_e              dest;
  logic               addr_ld;
  imm_word_u          imm;
  logic [2:0]         bit_num;
  logic [2:0]         rst_vec;
  logic [7:0]         int_vec;
  logic [15:0]        alu_out;
  flags_t             flags;
  logic [15:0]        addr_out;
  logic [7:0]         a_out;
  logic [15:0]        hl_out;
  logic [15:0]        pc_out;

  // Reference model registers.
  logic [7:0]  m_a;
  logic [7:0]  m_i;
  logic [7:0]  m_r;
  logic [15:0] m_hl;
  logic [15:0] m_ix;
  logic [15:0] m_iy;
  logic [15:0] m_pc;
  logic [15:0] m_tmp;
  logic [15:0] m_addr;
  flags_t      m_flags;

  // Operation driven last cycle and operation now in the stage.
  uop_t  cur;
  uop_t  stg;
  string test_name;
  int    n_errors = 0;
  int    n_checks = 0;
  int    cycles = 0;

  // Destinations in load order with the A select bit that reads each back.
  dest_e load_dst [8] = '{D_A, D_HL, D_IX, D_IY, D_PC, D_TMP, D_I, D_R};
  int    read_bit [8] = '{`AA_AA, `AA_HL, `AA_IX, `AA_IY, `AA_PC, `AA_TMP, `AA_II, `AA_RR};

  dp_top #(
    .RESET_PC (RESET_PC)
  ) UUT (
    .clkc      (clkc),
    .rst_n     (rst_n),
    .uop_valid (uop_valid),
    .alua_sel  (alua_sel),
    .alub_sel  (alub_sel),
    .alu_op    (alu_op),
    .dest      (dest),
    .addr_ld   (addr_ld),
    .imm       (imm),
    .bit_num   (bit_num),
    .rst_vec   (rst_vec),
    .int_vec   (int_vec),
    .alu_out   (alu_out),
    .flags     (flags),
    .addr_out  (addr_out),
    .a_out     (a_out),
    .hl_out    (hl_out),
    .pc_out    (pc_out)
  );

  initial begin
    clkc = 1'b0;
    forever #20 clkc = ~clkc;
  end

  // Run limit in cycles.
  always @(posedge clkc) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not complete within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic check_word(input string what, input logic [15:0] exp, input logic [15:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("** Error %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("** Error %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // Flags print as zero, sign, carry.
  task automatic check_flags(input flags_t exp, input flags_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("** Error %s: flags expected %b actual %b", test_name, exp, act);
    end
  endtask

  // A operand from the one-hot select.
  // The address side sees fewer sources.
  function automatic logic [15:0] a_source(input uop_t u, input logic addr_side);
    logic [15:0] v;
    logic [7:0]  daa;
    daa = ((m_a[3:0] > 4'd9) ? 8'h06 : 8'h00) |
          (((m_a[7:4] > 4'd9) || m_flags.carry) ? 8'h60 : 8'h00);
    v = 16'h0000;
    if (u.asel[`AA_ONE]) v = v | 16'h0001;
    if (u.asel[`AA_M1])  v = v | 16'hffff;
    if (u.asel[`AA_M2])  v = v | 16'hfffe;
    if (u.asel[`AA_IX])  v = v | m_ix;
    if (u.asel[`AA_IY])  v = v | m_iy;
    if (u.asel[`AA_INT]) v = v | {m_i, int_vec};
    if (u.asel[`AA_RST]) v = v | (16'(u.rv) * 16'd8);
    if (!addr_side) begin
      if (u.asel[`AA_HL])  v = v | m_hl;
      if (u.asel[`AA_PC])  v = v | m_pc;
      if (u.asel[`AA_TMP]) v = v | m_tmp;
      if (u.asel[`AA_AA])  v = v | {8'h00, m_a};
      if (u.asel[`AA_BIT]) v = v | {8'h00, 8'h01 << u.bn};
      if (u.asel[`AA_DAA]) v = v | {8'h00, daa};
      if (u.asel[`AA_II])  v = v | {8'h00, m_i};
      if (u.asel[`AA_RR])  v = v | {8'h00, m_r};
    end
    return v;
  endfunction

  // Checks alu_out of the stage, then applies its write-back to the model.
  task automatic stage_model();
    logic [15:0] a_in;
    logic [15:0] b_in;
    logic [16:0] wide;
    flags_t      f;
    a_in = a_source(stg, 1'b0);
    b_in = 16'h0000;
    if (stg.bsel[B_IMM]) b_in = b_in | stg.imm;
    if (stg.bsel[B_TMP]) b_in = b_in | m_tmp;
    if (stg.bsel[B_HL])  b_in = b_in | m_hl;
    if (stg.bsel[B_A])   b_in = b_in | {8'h00, m_a};
    case (stg.op)
      OP_ADD:  wide = {1'b0, a_in} + {1'b0, b_in};
      OP_SUB:  wide = {1'b0, a_in} - {1'b0, b_in};
      OP_AND:  wide = {1'b0, a_in & b_in};
      OP_OR:   wide = {1'b0, a_in | b_in};
      OP_XOR:  wide = {1'b0, a_in ^ b_in};
      default: wide = {1'b0, a_in};
    endcase
    f.zero  = (wide[15:0] == 16'h0000);
    f.sign  = wide[15];
    f.carry = wide[16];
    check_word("alu_out", wide[15:0], alu_out);
    if (stg.ld) begin
      m_addr = a_source(stg, 1'b1) + {{8{stg.imm[15]}}, stg.imm[15:8]};
    end
    m_flags = f;
    m_r = {m_r[7], m_r[6:0] + 7'd1};
    case (stg.dst)
      D_A:     m_a   = wide[7:0];
      D_HL:    m_hl  = wide[15:0];
      D_IX:    m_ix  = wide[15:0];
      D_IY:    m_iy  = wide[15:0];
      D_PC:    m_pc  = wide[15:0];
      D_TMP:   m_tmp = wide[15:0];
      D_I:     m_i   = wide[7:0];
      D_R:     m_r   = wide[7:0];
      default: ;
    endcase
  endtask

  task automatic check_state();
    check_byte("a_out", m_a, a_out);
    check_word("hl_out", m_hl, hl_out);
    check_word("pc_out", m_pc, pc_out);
    check_word("addr_out", m_addr, addr_out);
    check_flags(m_flags, flags);
  endtask

  // Drive on the rising edge and check at the falling edge.
  task automatic run_cycle(input uop_t u);
    @(posedge clkc);
    stg = cur;
    cur = u;
    uop_valid <= u.valid;
    alua_sel  <= u.asel;
    alub_sel  <= u.bsel;
    alu_op    <= u.op;
    dest      <= u.dst;
    addr_ld   <= u.ld;
    imm.word  <= u.imm;
    bit_num   <= u.bn;
    rst_vec   <= u.rv;
    int_vec   <= 8'($urandom);
    @(negedge clkc);
    check_state();
    if (stg.valid) begin
      stage_model();
    end
  endtask

  function automatic uop_t random_uop();
    uop_t u;
    int   k;
    u.valid = ($urandom_range(0, 6) != 0);
    k = $urandom_range(0, `ALUA_IDX + 1);
    u.asel = (k > `ALUA_IDX) ? '0 : (15'd1 << k);
    k = $urandom_range(0, ALUB_W);
    u.bsel = (k == ALUB_W) ? '0 : (4'd1 << k);
    u.op  = alu_op_e'($urandom_range(0, 5));
    u.dst = dest_e'($urandom_range(0, 8));
    u.ld  = ($urandom_range(0, 2) == 0);
    u.imm = 16'($urandom);
    u.bn  = 3'($urandom);
    u.rv  = 3'($urandom);
    return u;
  endfunction

  initial begin
    uop_t u;
    int   k;
    void'($urandom(32'hb450));
    rst_n     = 1'b0;
    uop_valid = 1'b0;
    alua_sel  = '0;
    alub_sel  = '0;
    alu_op    = OP_ADD;
    dest      = D_NONE;
    addr_ld   = 1'b0;
    imm       = '0;
    bit_num   = '0;
    rst_vec   = '0;
    int_vec   = '0;
    cur       = '0;
    stg       = '0;
    {m_a, m_i, m_r, m_hl, m_ix, m_iy, m_tmp, m_addr} = '0;
    m_pc    = RESET_PC;
    m_flags = '0;
    test_name = "reset";
    repeat (RST_CYCLES) @(posedge clkc);
    rst_n <= 1'b1;
    @(negedge clkc);
    check_state();

    // Immediate into each register, then read each one back through the ALU.
    test_name = "register load";
    for (k = 0; k < 8; k++) begin
      u = '0;
      u.valid = 1'b1;
      u.bsel  = 4'd1 << B_IMM;
      u.dst   = load_dst[k];
      u.imm   = 16'($urandom);
      run_cycle(u);
    end
    for (k = 0; k < 8; k++) begin
      u = '0;
      u.valid = 1'b1;
      u.asel  = 15'd1 << read_bit[k];
      u.op    = OP_PASSA;
      run_cycle(u);
    end

    // Random operations, address loads and idle cycles.
    test_name = "random alu";
    for (k = 0; k < N_RAND; k++) begin
      run_cycle(random_uop());
    end

    // Writer then reader of the same register with an occasional idle between.
    test_name = "back to back";
    for (k = 0; k < N_PAIRS; k++) begin
      u = random_uop();
      u.valid = 1'b1;
      u.dst   = load_dst[k % 8];
      run_cycle(u);
      if ($urandom_range(0, 2) == 0) begin
        run_cycle('0);
      end
      u = random_uop();
      u.valid = 1'b1;
      u.asel  = 15'd1 << read_bit[k % 8];
      u.bsel  = 4'd1 << B_IMM;
      u.op    = OP_ADD;
      run_cycle(u);
    end

    // Drain the pipeline.
    repeat (3) run_cycle('0);

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+include
verilog/dp_pkg.sv
verilog/ctl_reg.sv
verilog/reg_bank.sv
verilog/aluamux.sv
verilog/alubmux.sv
verilog/alu_core.sv
verilog/addr_alu.sv
verilog/dp_top.sv
test/tb_dp.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and fail if the log reports errors.
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f files.f --top-module tb_dp -o tb_dp_sim \
  && ./obj_dir/tb_dp_sim | tee sim.log \
  && ! grep -q "Finished with errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
